//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_exu_muldiv
FILELIST  = filelist.f
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf obj_dir

//--- filelist.f
verilog/muldiv_pkg.sv
verilog/exu_unit_if.sv
verilog/exu_mul.sv
verilog/exu_div.sv
verilog/exu_muldiv_ctrl.sv
verilog/exu_muldiv_top.sv
sim/tb_exu_muldiv.sv

//--- sim/muldiv_stimulus.txt
// op a b rd expected, all hex
// op 0..3 MUL MULH MULHSU MULHU, 4..7 DIV DIVU REM REMU
0 00000007 fffffffd 01 ffffffeb
0 12345678 00010000 02 56780000
1 80000000 80000000 03 40000000
1 ffffffff 00000005 04 ffffffff
2 ffffffff ffffffff 05 ffffffff
2 00000002 80000000 06 00000001
3 ffffffff ffffffff 07 fffffffe
3 80000000 00000004 08 00000002
4 ffffffec 00000003 09 fffffffa
4 80000000 ffffffff 0a 80000000
4 00000007 00000000 0b ffffffff
5 ffffffff 00000010 0c 0fffffff
5 00000064 00000000 0d ffffffff
6 ffffffec 00000003 0e fffffffe
6 80000000 ffffffff 0f 00000000
7 00000064 00000007 10 00000002
7 12345678 00000000 11 12345678
6 00000007 00000000 12 00000007

//--- sim/tb_exu_muldiv.sv
module tb_exu_muldiv import muldiv_pkg::*; ();

    localparam int WB_CREDITS = 2;
    localparam int NVEC       = 18;
    localparam int MUL_LAT    = 3;
    localparam int DIV_LAT    = 35;

    typedef struct packed {
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] cid;
        logic [XLEN-1:0]        res;
        int                     acc;
        int                     lat;
    } exp_t;

    logic                   clk = 1'b0;
    logic                   arst_n_i;
    logic                   req_i;
    muldiv_op_e             op_i;
    logic [XLEN-1:0]        rs1_data_i;
    logic [XLEN-1:0]        rs2_data_i;
    logic [REG_ADDR_W-1:0]  rd_addr_i;
    logic [COMMIT_ID_W-1:0] commit_id_i;
    logic                   int_assert_i;
    logic                   wb_credit_i;
    logic                   stall_o;
    logic                   wb_we_o;
    logic [XLEN-1:0]        wb_data_o;
    logic [REG_ADDR_W-1:0]  wb_addr_o;
    logic [COMMIT_ID_W-1:0] wb_commit_id_o;

    // five words per vector for op, a, b, rd and expected
    logic [XLEN-1:0]        vec_mem [NVEC*5];
    exp_t                   exp_q[$];
    int                     cyc = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     ntests = 0;
    int                     err_mark = 0;
    int                     wb_seen = 0;
    int                     credits_back = 0;
    bit                     hold = 1'b0;
    logic [COMMIT_ID_W-1:0] next_cid = '0;
    logic [COMMIT_ID_W-1:0] last_cid = '0;

    exu_muldiv_top #(.WB_CREDITS(WB_CREDITS)) UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                         input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // writeback monitor matching by commit id
    always @(posedge clk) begin
        int hit;
        if (wb_we_o === 1'b1) begin
            wb_seen  <= wb_seen + 1;
            last_cid <= wb_commit_id_o;
            hit = -1;
            foreach (exp_q[i]) begin
                if (exp_q[i].cid == wb_commit_id_o) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                errors++;
                $display("unexpected writeback with commit id %0d at time %0t",
                         wb_commit_id_o, $time);
            end else begin
                check(wb_data_o, exp_q[hit].res, "writeback data");
                check(XLEN'(wb_addr_o), XLEN'(exp_q[hit].rd), "writeback address");
                if (exp_q[hit].lat != 0) begin
                    check(XLEN'(cyc - exp_q[hit].acc), XLEN'(exp_q[hit].lat), "latency");
                end
                exp_q.delete(hit);
            end
        end
    end

    // consumer frees one slot per writeback after a random delay
    initial begin
        void'($urandom(32'hf6a2_6a9d));
        forever begin
            @(posedge clk);
            if (!hold && wb_seen > credits_back) begin
                repeat ($urandom % 4) @(posedge clk);
                wb_credit_i  <= 1'b1;
                credits_back <= credits_back + 1;
                @(posedge clk);
                wb_credit_i <= 1'b0;
            end
        end
    end

    task automatic start_req(input int v);
        @(posedge clk);
        req_i       <= 1'b1;
        op_i        <= muldiv_op_e'(vec_mem[v*5][2:0]);
        rs1_data_i  <= vec_mem[v*5+1];
        rs2_data_i  <= vec_mem[v*5+2];
        rd_addr_i   <= vec_mem[v*5+3][REG_ADDR_W-1:0];
        commit_id_i <= next_cid;
    endtask

    // lat of zero skips the latency check
    task automatic await_accept(input int v, input int lat);
        exp_t e;
        @(posedge clk);
        while (stall_o) begin
            @(posedge clk);
        end
        req_i <= 1'b0;
        e.rd  = vec_mem[v*5+3][REG_ADDR_W-1:0];
        e.cid = next_cid;
        e.res = vec_mem[v*5+4];
        e.acc = cyc;
        e.lat = lat;
        exp_q.push_back(e);
        next_cid = next_cid + COMMIT_ID_W'(1);
    endtask

    task automatic issue(input int v, input int lat);
        start_req(v);
        await_accept(v, lat);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic end_test(input string name);
        ntests++;
        $display("test %0d %s %s", ntests, name, (errors == err_mark) ? "ok" : "FAILED");
        err_mark = errors;
    endtask

    initial begin
        int                     base;
        logic [COMMIT_ID_W-1:0] mul_cid;
        $readmemh("sim/muldiv_stimulus.txt", vec_mem);
        arst_n_i     <= 1'b0;
        req_i        <= 1'b0;
        op_i         <= MUL;
        rs1_data_i   <= '0;
        rs2_data_i   <= '0;
        rd_addr_i    <= '0;
        commit_id_i  <= '0;
        int_assert_i <= 1'b0;
        wb_credit_i  <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) @(posedge clk);

        // opcode bit 2 marks a divide
        for (int v = 0; v < NVEC; v++) begin
            if (vec_mem[v*5][2] == 1'b0) begin
                issue(v, MUL_LAT);
                drain();
            end
        end
        end_test("multiply opcodes");

        for (int v = 0; v < NVEC; v++) begin
            if (vec_mem[v*5][2] == 1'b1) begin
                issue(v, DIV_LAT);
                drain();
            end
        end
        end_test("divide opcodes");

        // multiply overtakes a running divide
        base = wb_seen;
        issue(8, DIV_LAT);
        mul_cid = next_cid;
        issue(0, MUL_LAT);
        while (wb_seen == base) begin
            @(posedge clk);
        end
        check(XLEN'(last_cid), XLEN'(mul_cid), "first writeback commit id");
        drain();
        end_test("multiply during divide");

        // consumer stops returning credits
        while (wb_seen != credits_back) begin
            @(posedge clk);
        end
        hold <= 1'b1;
        base = wb_seen;
        for (int k = 0; k < WB_CREDITS + 1; k++) begin
            issue(k, 0);
        end
        repeat (10) @(posedge clk);
        check(XLEN'(wb_seen - base), XLEN'(WB_CREDITS), "writebacks without credit");
        start_req(3);
        repeat (3) @(posedge clk);
        check(XLEN'(stall_o), 1, "stall with pending result");
        hold <= 1'b0;
        await_accept(3, 0);
        drain();
        end_test("credit starvation");

        base = wb_seen;
        int_assert_i <= 1'b1;
        start_req(15);
        repeat (DIV_LAT + 5) @(posedge clk);
        check(XLEN'(stall_o), 1, "stall under interrupt");
        check(XLEN'(wb_seen - base), 0, "writebacks under interrupt");
        int_assert_i <= 1'b0;
        await_accept(15, DIV_LAT);
        drain();
        end_test("interrupt blocks issue");

        $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // about 40 cycles per vector plus slack for the directed tests
    initial begin
        #((NVEC * 40 + 200) * 20);
        $display("simulation timed out before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog/exu_div.sv
module exu_div import muldiv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    exu_unit_if.unit bus
);

    localparam int CNT_W = $clog2(XLEN);

    div_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic             vld;
    logic             take;
    logic             sgn;
    logic [XLEN-1:0]  abs_a;
    logic [XLEN-1:0]  abs_b;
    logic [XLEN-1:0]  quo;
    logic [XLEN-1:0]  rem;
    logic [XLEN-1:0]  dvs;
    logic [XLEN-1:0]  dvd_q;
    logic             neg_q;
    logic             neg_r;
    logic             div0;
    logic             rem_sel;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    logic [XLEN-1:0]  fix_q;
    logic [XLEN-1:0]  fix_r;
    logic [XLEN-1:0]  res;

    assign take  = bus.start && !bus.busy;
    assign sgn   = (bus.op == DIV) || (bus.op == REM);
    assign abs_a = (sgn && bus.operand_a[XLEN-1]) ? -bus.operand_a : bus.operand_a;
    assign abs_b = (sgn && bus.operand_b[XLEN-1]) ? -bus.operand_b : bus.operand_b;

    // one restoring step: shift in next dividend bit, try subtract
    assign shifted = {rem, quo[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs};

    // min / -1 needs no special case, negating 2^31 gives the dividend back
    assign fix_q = div0 ? '1 : (neg_q ? -quo : quo);
    assign fix_r = div0 ? dvd_q : (neg_r ? -rem : rem);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= IDLE;
            cnt   <= '0;
            vld   <= 1'b0;
        end else begin
            vld <= (state == DONE);
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= BUSY;
                        cnt   <= '0;
                    end
                end
                BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(XLEN - 1)) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            quo     <= abs_a;
            rem     <= '0;
            dvs     <= abs_b;
            dvd_q   <= bus.operand_a;
            neg_q   <= sgn && (bus.operand_a[XLEN-1] ^ bus.operand_b[XLEN-1]);
            neg_r   <= sgn && bus.operand_a[XLEN-1];
            div0    <= (bus.operand_b == '0);
            rem_sel <= (bus.op == REM) || (bus.op == REMU);
        end else if (state == BUSY) begin
            if (!diff[XLEN]) begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
        // fix-up cycle
        if (state == DONE) begin
            res <= rem_sel ? fix_r : fix_q;
        end
    end

    // busy also covers the valid cycle
    assign bus.busy   = (state != IDLE) | vld;
    assign bus.valid  = vld;
    assign bus.result = res;

endmodule

//--- verilog/exu_mul.sv
module exu_mul import muldiv_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    exu_unit_if.unit bus
);

    logic                      take;
    logic                      a_sgn;
    logic                      b_sgn;
    logic                      s1_vld;
    muldiv_op_e                s1_op;
    logic signed [XLEN:0]      s1_a;
    logic signed [XLEN:0]      s1_b;
    logic signed [2*XLEN+1:0]  prod;
    logic                      s2_vld;
    logic [XLEN-1:0]           s2_res;

    // no new work while either stage is occupied
    assign take = bus.start && !bus.busy;

    // rs1 is signed for MULH and MULHSU and rs2 only for MULH
    assign a_sgn = (bus.op == MULH) || (bus.op == MULHSU);
    assign b_sgn = (bus.op == MULH);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            s1_vld <= take;
            s2_vld <= s1_vld;
        end
    end

    // stage one extends operands to 33 bits
    always_ff @(posedge clk) begin
        if (take) begin
            s1_op <= bus.op;
            s1_a  <= {a_sgn & bus.operand_a[XLEN-1], bus.operand_a};
            s1_b  <= {b_sgn & bus.operand_b[XLEN-1], bus.operand_b};
        end
    end

    // one signed multiply covers all four flavours
    assign prod = (2*XLEN+2)'(s1_a) * (2*XLEN+2)'(s1_b);

    // stage two picks the word
    always_ff @(posedge clk) begin
        if (s1_vld) begin
            s2_res <= (s1_op == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
        end
    end

    assign bus.busy   = s1_vld | s2_vld;
    assign bus.valid  = s2_vld;
    assign bus.result = s2_res;

endmodule

//--- verilog/exu_muldiv_ctrl.sv
module exu_muldiv_ctrl import muldiv_pkg::*; #(
    parameter int WB_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   req_i,
    input  muldiv_op_e             op_i,
    input  logic [XLEN-1:0]        rs1_data_i,
    input  logic [XLEN-1:0]        rs2_data_i,
    input  logic [REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    input  logic                   int_assert_i,
    input  logic                   wb_credit_i,
    output logic                   stall_o,
    output logic                   wb_we_o,
    output logic [XLEN-1:0]        wb_data_o,
    output logic [REG_ADDR_W-1:0]  wb_addr_o,
    output logic [COMMIT_ID_W-1:0] wb_commit_id_o,
    exu_unit_if.ctrl               mul_bus,
    exu_unit_if.ctrl               div_bus
);

    localparam int CNT_W = $clog2(WB_CREDITS + 1);

    logic                   is_div;
    logic                   mul_free;
    logic                   div_free;
    logic                   mul_pend;
    logic                   div_pend;
    logic [REG_ADDR_W-1:0]  mul_rd;
    logic [REG_ADDR_W-1:0]  div_rd;
    logic [COMMIT_ID_W-1:0] mul_cid;
    logic [COMMIT_ID_W-1:0] div_cid;
    logic [XLEN-1:0]        mul_res;
    logic [XLEN-1:0]        div_res;
    logic [CNT_W-1:0]       credit_cnt;
    logic                   wb_mul;
    logic                   wb_div;

    assign is_div = op_i inside {DIV, DIVU, REM, REMU};

    // a unit is free once idle and its last result has left
    assign mul_free = !mul_bus.busy && !mul_pend;
    assign div_free = !div_bus.busy && !div_pend;

    assign stall_o = int_assert_i || (req_i && (is_div ? !div_free : !mul_free));

    assign mul_bus.start     = req_i && !is_div && mul_free && !int_assert_i;
    assign mul_bus.op        = op_i;
    assign mul_bus.operand_a = rs1_data_i;
    assign mul_bus.operand_b = rs2_data_i;

    assign div_bus.start     = req_i && is_div && div_free && !int_assert_i;
    assign div_bus.op        = op_i;
    assign div_bus.operand_a = rs1_data_i;
    assign div_bus.operand_b = rs2_data_i;

    // multiplier wins when both are waiting
    assign wb_mul = mul_pend && (credit_cnt != '0);
    assign wb_div = div_pend && !mul_pend && (credit_cnt != '0);

    assign wb_we_o        = wb_mul | wb_div;
    assign wb_data_o      = wb_mul ? mul_res : div_res;
    assign wb_addr_o      = wb_mul ? mul_rd : div_rd;
    assign wb_commit_id_o = wb_mul ? mul_cid : div_cid;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mul_pend <= 1'b0;
            div_pend <= 1'b0;
        end else begin
            if (mul_bus.valid) begin
                mul_pend <= 1'b1;
            end else if (wb_mul) begin
                mul_pend <= 1'b0;
            end
            if (div_bus.valid) begin
                div_pend <= 1'b1;
            end else if (wb_div) begin
                div_pend <= 1'b0;
            end
        end
    end

    // destination and id ride along with each unit
    always_ff @(posedge clk) begin
        if (mul_bus.start) begin
            mul_rd  <= rd_addr_i;
            mul_cid <= commit_id_i;
        end
        if (div_bus.start) begin
            div_rd  <= rd_addr_i;
            div_cid <= commit_id_i;
        end
        if (mul_bus.valid) begin
            mul_res <= mul_bus.result;
        end
        if (div_bus.valid) begin
            div_res <= div_bus.result;
        end
    end

    // one credit per pulse, one back per credit cycle, capped at reset value
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CNT_W'(WB_CREDITS);
        end else if (wb_we_o && !wb_credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!wb_we_o && wb_credit_i && credit_cnt != CNT_W'(WB_CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

endmodule

//--- verilog/exu_muldiv_top.sv
module exu_muldiv_top import muldiv_pkg::*; #(
    parameter int WB_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   req_i,
    input  muldiv_op_e             op_i,
    input  logic [XLEN-1:0]        rs1_data_i,
    input  logic [XLEN-1:0]        rs2_data_i,
    input  logic [REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [COMMIT_ID_W-1:0] commit_id_i,
    input  logic                   int_assert_i,
    input  logic                   wb_credit_i,
    output logic                   stall_o,
    output logic                   wb_we_o,
    output logic [XLEN-1:0]        wb_data_o,
    output logic [REG_ADDR_W-1:0]  wb_addr_o,
    output logic [COMMIT_ID_W-1:0] wb_commit_id_o
);

    exu_unit_if mul_bus ();
    exu_unit_if div_bus ();

    exu_muldiv_ctrl #(
        .WB_CREDITS(WB_CREDITS)
    ) u_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .op_i          (op_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .rd_addr_i     (rd_addr_i),
        .commit_id_i   (commit_id_i),
        .int_assert_i  (int_assert_i),
        .wb_credit_i   (wb_credit_i),
        .stall_o       (stall_o),
        .wb_we_o       (wb_we_o),
        .wb_data_o     (wb_data_o),
        .wb_addr_o     (wb_addr_o),
        .wb_commit_id_o(wb_commit_id_o),
        .mul_bus       (mul_bus.ctrl),
        .div_bus       (div_bus.ctrl)
    );

    exu_mul u_mul (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .bus     (mul_bus.unit)
    );

    exu_div u_div (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .bus     (div_bus.unit)
    );

endmodule

//--- verilog/exu_unit_if.sv
// control block <-> one arithmetic unit
interface exu_unit_if import muldiv_pkg::*; ();

    // request side
    logic            start;
    muldiv_op_e      op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;

    // response side
    logic            busy;
    logic            valid;
    logic [XLEN-1:0] result;

    modport ctrl (
        output start,
        output op,
        output operand_a,
        output operand_b,
        input  busy,
        input  valid,
        input  result
    );

    modport unit (
        input  start,
        input  op,
        input  operand_a,
        input  operand_b,
        output busy,
        output valid,
        output result
    );

endinterface

//--- verilog/muldiv_pkg.sv
package muldiv_pkg;

    // datapath widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // RV32M opcodes, funct3 order
    // multiplies in the low half, divides in the high half
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    // divider sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } div_state_e;

endpackage
